// File: design/pl_macros.svh
// prefix loader widths
`ifndef PL_MACROS_SVH
`define PL_MACROS_SVH

// input beat and history-buffer line.
`define PL_BEAT_W      64
`define PL_LINE_W      128

// line address inside one prefix slot.
`define PL_ADDR_W      6

// lines per half-block, high halves start here.
`define PL_HALF_LINES  32

// prefix slots in the history buffer.
`define PL_NUM_SLOTS   3

// header size field.
`define PL_SIZE_W      7

// expander prefix count, size x 1024.
`define PL_CNT_W       17
`define PL_CNT_SHIFT   10

// address generator tail pointer, size x 64.
`define PL_TAIL_W      13
`define PL_TAIL_SHIFT  6

`endif

// File: design/pl_pkg.sv
// prefix loader types
`default_nettype none

`include "pl_macros.svh"

package pl_pkg;

   typedef logic [1:0] slot_id_t;

   typedef enum logic [1:0] {
      slot_free,
      slot_loading,
      slot_held
   } slot_state_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // input side.
   typedef struct packed {
      logic                  sof;
      logic                  last;
      logic [`PL_BEAT_W-1:0] data;
   } prefix_beat_t;

   typedef struct packed {
      logic                  trace_bit;
      logic [`PL_SIZE_W-1:0] data_sz;
   } prefix_hdr_t;

   // size zero means no prefix attached.
   typedef struct packed {
      logic                  trace;
      logic [`PL_SIZE_W-1:0] size;
      slot_id_t              slot;
   } pl_tag_t;

   typedef struct packed {
      logic    valid;
      pl_tag_t tag;
   } slot_event_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // output side.
   typedef struct packed {
      logic                  wr;
      slot_id_t              slot;
      logic [`PL_ADDR_W-1:0] addr;
      logic [`PL_LINE_W-1:0] data;
   } hb_wr_t;

   typedef struct packed {
      logic                 load;
      logic [`PL_CNT_W-1:0] prefix_cnt;
      logic                 trace;
   } ep_load_t;

   typedef struct packed {
      logic                  load;
      logic [`PL_TAIL_W-1:0] tail_ptr;
   } ag_tail_t;

endpackage

`default_nettype wire

// File: design/pl_slot_ctrl.sv
// prefix slot control
`timescale 1ns/1ns
`default_nettype none

`include "pl_macros.svh"

module pl_slot_ctrl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     beat_valid,
   input  pl_pkg::prefix_beat_t     beat,
   input  logic                     hdr_valid,
   input  pl_pkg::prefix_hdr_t      hdr,
   input  logic                     hdr_empty,
   input  pl_pkg::slot_event_t      hold_pop,
   input  pl_pkg::slot_event_t      slot_release,
   output pl_pkg::slot_event_t      load_slot,
   output pl_pkg::slot_event_t      tag_wr,
   output logic                     pre_prefix_ready,
   output logic [`PL_NUM_SLOTS-1:0] in_use
);

   pl_pkg::slot_state_e      state [`PL_NUM_SLOTS];
   logic [`PL_NUM_SLOTS-1:0] loading;
   logic [`PL_NUM_SLOTS-1:0] free;
   logic                     any_loading;
   logic                     alloc;
   pl_pkg::slot_id_t         alloc_slot;
   pl_pkg::slot_id_t         load_id;
   logic                     tag_vld;
   pl_pkg::pl_tag_t          tag_q;

   always_comb begin
      for (int i = 0; i < `PL_NUM_SLOTS; i++) begin
         loading[i] = (state[i] == pl_pkg::slot_loading);
         free[i]    = (state[i] == pl_pkg::slot_free);
      end
   end

   assign any_loading = |loading;

   // lowest free slot wins.
   always_comb begin
      alloc_slot = pl_pkg::slot_id_t'(0);
      for (int i = `PL_NUM_SLOTS - 1; i >= 0; i--) begin
         if (free[i]) begin
            alloc_slot = pl_pkg::slot_id_t'(i);
         end
      end
   end

   // headers with nothing loading fall back to the last slot.
   always_comb begin
      load_id = pl_pkg::slot_id_t'(`PL_NUM_SLOTS - 1);
      for (int i = `PL_NUM_SLOTS - 1; i >= 0; i--) begin
         if (loading[i]) begin
            load_id = pl_pkg::slot_id_t'(i);
         end
      end
   end

   assign pre_prefix_ready = any_loading || (hdr_empty && (|free));
   assign alloc = beat_valid && pre_prefix_ready && beat.sof && (|free);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // slot state, free -> loading -> held -> free.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `PL_NUM_SLOTS; i++) begin
            state[i] <= pl_pkg::slot_free;
         end
      end else begin
         for (int i = 0; i < `PL_NUM_SLOTS; i++) begin
            case (state[i])
               pl_pkg::slot_free: begin
                  if (alloc && (alloc_slot == pl_pkg::slot_id_t'(i))) begin
                     state[i] <= pl_pkg::slot_loading;
                  end
               end
               pl_pkg::slot_loading: begin
                  if (tag_vld) begin
                     state[i] <= pl_pkg::slot_held;
                  end
               end
               pl_pkg::slot_held: begin
                  if (slot_release.valid && (slot_release.tag.slot == pl_pkg::slot_id_t'(i))) begin
                     state[i] <= pl_pkg::slot_free;
                  end
               end
               default: state[i] <= pl_pkg::slot_free;
            endcase
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // header tagging.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tag_vld <= 1'b0;
      end else begin
         tag_vld <= hdr_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_valid) begin
         tag_q.trace <= hdr.trace_bit;
         tag_q.size  <= hdr.data_sz;
         tag_q.slot  <= load_id;
      end
   end

   // in-use follows the descriptor leaving the hold stage.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_use <= '0;
      end else if (slot_release.valid) begin
         in_use[slot_release.tag.slot] <= 1'b0;
      end else if (hold_pop.valid) begin
         if (hold_pop.tag.size != '0) begin
            in_use <= `PL_NUM_SLOTS'(1) << hold_pop.tag.slot;
         end else begin
            in_use <= '0;
         end
      end
   end

   always_comb begin
      load_slot          = '0;
      load_slot.valid    = any_loading;
      load_slot.tag.slot = load_id;
   end

   assign tag_wr.valid = tag_vld;
   assign tag_wr.tag   = tag_q;

   // a second sof before the header would open two slots.
   a_one_loading: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(loading));

   a_release_owned: assert property (@(posedge clk) disable iff (!rst_n)
      slot_release.valid |-> (state[slot_release.tag.slot] != pl_pkg::slot_free));

endmodule

`default_nettype wire

// File: design/pl_beat_packer.sv
// prefix beat packer
`timescale 1ns/1ns
`default_nettype none

`include "pl_macros.svh"

module pl_beat_packer (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 beat_valid,
   input  pl_pkg::prefix_beat_t beat,
   input  pl_pkg::slot_event_t  load_slot,
   output pl_pkg::hb_wr_t       hb_wr
);

   localparam int HALF = `PL_BEAT_W / 2;

   logic [1:0]              beat_cnt;
   logic [`PL_BEAT_W-1:0]   beat_q [4];
   logic [`PL_BEAT_W-1:0]   beat0_d;
   logic                    wr_lo;
   logic                    wr_tgl;
   logic                    last_d1;
   logic                    last_d2;
   logic [`PL_ADDR_W-2:0]   line_cnt;
   logic                    wr_q;
   pl_pkg::slot_id_t        slot_q;
   logic [`PL_ADDR_W-1:0]   addr_q;
   logic [`PL_LINE_W-1:0]   data_q;
   logic [`PL_LINE_W-1:0]   lo_line;
   logic [`PL_LINE_W-1:0]   hi_line;

   // low halves of the group, oldest beat in the lsbs.
   assign lo_line = {beat_q[3][HALF-1:0], beat_q[2][HALF-1:0],
                     beat_q[1][HALF-1:0], beat_q[0][HALF-1:0]};

   // beat 0 may already be overwritten by the next group.
   assign hi_line = {beat_q[3][`PL_BEAT_W-1:HALF], beat_q[2][`PL_BEAT_W-1:HALF],
                     beat_q[1][`PL_BEAT_W-1:HALF], beat0_d[`PL_BEAT_W-1:HALF]};

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // group counting and write sequencing.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         beat_cnt <= '0;
         wr_lo    <= 1'b0;
         wr_tgl   <= 1'b0;
         last_d1  <= 1'b0;
         last_d2  <= 1'b0;
         line_cnt <= '0;
         wr_q     <= 1'b0;
      end else begin
         if (beat_valid) begin
            if (beat.last) begin
               beat_cnt <= '0;
            end else begin
               beat_cnt <= beat_cnt + 2'd1;
            end
         end

         wr_lo   <= beat_valid && (beat_cnt == 2'd3);
         wr_tgl  <= wr_lo;
         last_d1 <= beat_valid && beat.last;
         last_d2 <= last_d1;

         if (last_d2) begin
            line_cnt <= '0;
         end else if (wr_tgl) begin
            line_cnt <= line_cnt + 1'b1;
         end

         wr_q <= (wr_lo || wr_tgl) && load_slot.valid;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // beat storage and write payload.
   always_ff @(posedge clk) begin
      if (beat_valid) begin
         beat_q[beat_cnt] <= beat.data;
      end

      if (wr_lo) begin
         beat0_d <= beat_q[0];
         addr_q  <= {1'b0, line_cnt};
         data_q  <= lo_line;
      end else if (wr_tgl) begin
         addr_q <= {1'b0, line_cnt} + `PL_ADDR_W'(`PL_HALF_LINES);
         data_q <= hi_line;
      end

      slot_q <= load_slot.tag.slot;
   end

   always_comb begin
      hb_wr.wr   = wr_q;
      hb_wr.slot = slot_q;
      hb_wr.addr = addr_q;
      hb_wr.data = data_q;
   end

   // a finished group always has a loading slot to write into.
   a_wr_loading: assert property (@(posedge clk) disable iff (!rst_n)
      (wr_lo || wr_tgl) |-> load_slot.valid);

endmodule

`default_nettype wire

// File: design/pl_desc_pipe.sv
// prefix descriptor pipe
`timescale 1ns/1ns
`default_nettype none

`include "pl_macros.svh"

module pl_desc_pipe (
   input  logic                clk,
   input  logic                rst_n,
   input  pl_pkg::slot_event_t tag_wr,
   input  logic                eof,
   output logic                hdr_empty,
   output pl_pkg::slot_event_t hold_pop,
   output pl_pkg::slot_event_t slot_release,
   output pl_pkg::ep_load_t    ep_load,
   output pl_pkg::ag_tail_t    ag_tail
);

   logic                  hdr_vld;
   logic                  hold_vld;
   logic                  data_vld;
   pl_pkg::pl_tag_t       hdr_tag;
   pl_pkg::pl_tag_t       hold_tag;
   pl_pkg::pl_tag_t       data_tag;
   logic                  hdr_rd;
   logic                  hold_rd;
   logic                  data_rd;
   logic                  load_q;
   logic [`PL_CNT_W-1:0]  cnt_q;
   logic                  trace_q;
   logic [`PL_TAIL_W-1:0] tail_q;

   // an entry moves on when the next stage is empty.
   assign hdr_rd  = hdr_vld && !hold_vld;
   assign hold_rd = hold_vld && !data_vld;
   assign data_rd = data_vld && eof;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stage occupancy.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hdr_vld  <= 1'b0;
         hold_vld <= 1'b0;
         data_vld <= 1'b0;
      end else begin
         hdr_vld  <= tag_wr.valid || (hdr_vld && !hdr_rd);
         hold_vld <= hdr_rd || (hold_vld && !hold_rd);
         data_vld <= hold_rd || (data_vld && !data_rd);
      end
   end

   always_ff @(posedge clk) begin
      if (tag_wr.valid) begin
         hdr_tag <= tag_wr.tag;
      end
      if (hdr_rd) begin
         hold_tag <= hdr_tag;
      end
      if (hold_rd) begin
         data_tag <= hold_tag;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // expander and tail loads on entry to the data stage.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         load_q <= 1'b0;
      end else begin
         load_q <= hold_rd;
      end
   end

   always_ff @(posedge clk) begin
      if (hold_rd) begin
         cnt_q   <= `PL_CNT_W'(hold_tag.size) << `PL_CNT_SHIFT;
         tail_q  <= `PL_TAIL_W'(hold_tag.size) << `PL_TAIL_SHIFT;
         trace_q <= hold_tag.trace;
      end
   end

   assign hdr_empty = !hdr_vld;

   assign hold_pop.valid = hold_rd;
   assign hold_pop.tag   = hold_tag;

   // zero-size entries hold no slot.
   assign slot_release.valid = data_rd && (data_tag.size != '0);
   assign slot_release.tag   = data_tag;

   always_comb begin
      ep_load.load       = load_q;
      ep_load.prefix_cnt = cnt_q;
      ep_load.trace      = trace_q;
      ag_tail.load       = load_q;
      ag_tail.tail_ptr   = tail_q;
   end

   // the header side must wait for hdr_ready.
   a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
      tag_wr.valid |-> !hdr_vld);

endmodule

`default_nettype wire

// File: design/prefix_loader.sv
// prefix loader top
`timescale 1ns/1ns
`default_nettype none

`include "pl_macros.svh"

module prefix_loader (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     beat_valid,
   input  pl_pkg::prefix_beat_t     beat,
   input  logic                     hdr_valid,
   input  pl_pkg::prefix_hdr_t      hdr,
   input  logic                     eof,
   output logic                     pre_prefix_ready,
   output logic                     hdr_ready,
   output pl_pkg::hb_wr_t           hb_wr,
   output pl_pkg::ep_load_t         ep_load,
   output pl_pkg::ag_tail_t         ag_tail,
   output logic [`PL_NUM_SLOTS-1:0] in_use
);

   pl_pkg::slot_event_t load_slot;
   pl_pkg::slot_event_t tag_wr;
   pl_pkg::slot_event_t hold_pop;
   pl_pkg::slot_event_t slot_release;

   // hdr_ready is the hdr stage empty flag.
   pl_slot_ctrl u_slot_ctrl (
      .clk              (clk),
      .rst_n            (rst_n),
      .beat_valid       (beat_valid),
      .beat             (beat),
      .hdr_valid        (hdr_valid),
      .hdr              (hdr),
      .hdr_empty        (hdr_ready),
      .hold_pop         (hold_pop),
      .slot_release     (slot_release),
      .load_slot        (load_slot),
      .tag_wr           (tag_wr),
      .pre_prefix_ready (pre_prefix_ready),
      .in_use           (in_use)
   );

   pl_beat_packer u_beat_packer (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat_valid (beat_valid),
      .beat       (beat),
      .load_slot  (load_slot),
      .hb_wr      (hb_wr)
   );

   pl_desc_pipe u_desc_pipe (
      .clk          (clk),
      .rst_n        (rst_n),
      .tag_wr       (tag_wr),
      .eof          (eof),
      .hdr_empty    (hdr_ready),
      .hold_pop     (hold_pop),
      .slot_release (slot_release),
      .ep_load      (ep_load),
      .ag_tail      (ag_tail)
   );

endmodule

`default_nettype wire

// File: verif/prefix_loader_tb.sv
// prefix loader testbench
`timescale 1ns/1ns
`default_nettype none

`include "pl_macros.svh"

module prefix_loader_tb;

   localparam int HALF_W = `PL_BEAT_W / 2;
   // summed length of the five tests, in clocks.
   localparam int TEST_CYCLES    = 400;
   localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 200;
   localparam int IDLE_LIMIT     = 50;

   typedef struct packed {
      logic [`PL_CNT_W-1:0]     cnt;
      logic                     trace;
      logic [`PL_TAIL_W-1:0]    tail;
      logic [`PL_NUM_SLOTS-1:0] slots;
   } load_exp_t;

   logic                     clk = 1'b0;
   logic                     rst_n;
   logic                     beat_valid;
   pl_pkg::prefix_beat_t     beat;
   logic                     hdr_valid;
   pl_pkg::prefix_hdr_t      hdr;
   logic                     eof;
   logic                     pre_prefix_ready;
   logic                     hdr_ready;
   pl_pkg::hb_wr_t           hb_wr;
   pl_pkg::ep_load_t         ep_load;
   pl_pkg::ag_tail_t         ag_tail;
   logic [`PL_NUM_SLOTS-1:0] in_use;

   pl_pkg::hb_wr_t           wr_exp [$];
   load_exp_t                load_exp [$];
   pl_pkg::pl_tag_t          pipe_q [$];
   pl_pkg::hb_wr_t           exp_w;
   load_exp_t                exp_ld;
   logic [`PL_NUM_SLOTS-1:0] slot_taken;
   int                       cur_slot;
   int                       loads_seen;
   int                       eofs_sent;
   int                       wr_seen;
   int                       err_cnt;
   int                       chk_cnt;
   int                       cycle_cnt = 0;

   prefix_loader u_prefix_loader (
      .clk              (clk),
      .rst_n            (rst_n),
      .beat_valid       (beat_valid),
      .beat             (beat),
      .hdr_valid        (hdr_valid),
      .hdr              (hdr),
      .eof              (eof),
      .pre_prefix_ready (pre_prefix_ready),
      .hdr_ready        (hdr_ready),
      .hb_wr            (hb_wr),
      .ep_load          (ep_load),
      .ag_tail          (ag_tail),
      .in_use           (in_use)
   );

   always #5 clk = ~clk;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // reference model.
   function automatic logic [`PL_LINE_W-1:0] ref_line(
      input logic [3:0][`PL_BEAT_W-1:0] grp,
      input logic                       hi
   );
      logic [`PL_LINE_W-1:0] line;
      line = '0;
      for (int k = 0; k < 4; k++) begin
         if (hi) begin
            line[k*HALF_W +: HALF_W] = grp[k][HALF_W +: HALF_W];
         end else begin
            line[k*HALF_W +: HALF_W] = grp[k][0 +: HALF_W];
         end
      end
      return line;
   endfunction

   // count is size x 1024, tail is size x 64.
   function automatic load_exp_t ref_load(input pl_pkg::pl_tag_t t);
      load_exp_t e;
      e.cnt   = `PL_CNT_W'(int'(t.size) * 1024);
      e.tail  = `PL_TAIL_W'(int'(t.size) * 64);
      e.trace = t.trace;
      e.slots = (t.size != '0) ? (`PL_NUM_SLOTS'(1) << t.slot) : '0;
      return e;
   endfunction

   function automatic int lowest_free();
      for (int k = 0; k < `PL_NUM_SLOTS; k++) begin
         if (!slot_taken[k]) begin
            return k;
         end
      end
      return -1;
   endfunction

   task automatic check_fail(input string what);
      $display("CHECK FAILED at %0t: %s", $time, what);
      err_cnt++;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus.
   task automatic send_prefix(input int n_beats);
      pl_pkg::prefix_beat_t         b;
      logic [3:0][`PL_BEAT_W-1:0]   grp;
      pl_pkg::hb_wr_t               w;
      int                           i;
      cur_slot = lowest_free();
      if (cur_slot < 0) begin
         $display("no free slot left for a new prefix at %0t", $time);
         err_cnt++;
         cur_slot = 0;
      end
      slot_taken[cur_slot] = 1'b1;
      grp = '0;
      @(posedge clk);
      while (!pre_prefix_ready) begin
         @(posedge clk);
      end
      for (i = 0; i < n_beats; i++) begin
         b.sof  = (i == 0);
         b.last = (i == n_beats - 1);
         b.data = {$urandom, $urandom};
         beat_valid <= 1'b1;
         beat       <= b;
         grp[2'(i % 4)] = b.data;
         if (i % 4 == 3) begin
            w.wr   = 1'b1;
            w.slot = pl_pkg::slot_id_t'(cur_slot);
            w.addr = `PL_ADDR_W'(i / 4);
            w.data = ref_line(grp, 1'b0);
            wr_exp.push_back(w);
            w.addr = `PL_ADDR_W'(i / 4 + `PL_HALF_LINES);
            w.data = ref_line(grp, 1'b1);
            wr_exp.push_back(w);
         end
         @(posedge clk);
      end
      beat_valid <= 1'b0;
      beat       <= '0;
      repeat (2) @(posedge clk);
   endtask

   // without a loading slot the tag falls back to the last slot.
   task automatic send_hdr(input int size, input logic trace);
      pl_pkg::prefix_hdr_t h;
      pl_pkg::pl_tag_t     t;
      h.trace_bit = trace;
      h.data_sz   = `PL_SIZE_W'(size);
      t.trace     = trace;
      t.size      = `PL_SIZE_W'(size);
      t.slot      = pl_pkg::slot_id_t'((cur_slot >= 0) ? cur_slot : `PL_NUM_SLOTS - 1);
      pipe_q.push_back(t);
      load_exp.push_back(ref_load(t));
      cur_slot = -1;
      @(posedge clk);
      while (!hdr_ready) begin
         @(posedge clk);
      end
      hdr_valid <= 1'b1;
      hdr       <= h;
      @(posedge clk);
      hdr_valid <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   // waits until the oldest descriptor sits in the data stage.
   task automatic send_eof();
      pl_pkg::pl_tag_t t;
      @(posedge clk);
      while (loads_seen <= eofs_sent) begin
         @(posedge clk);
      end
      eof <= 1'b1;
      @(posedge clk);
      eof <= 1'b0;
      t = pipe_q.pop_front();
      eofs_sent++;
      if (t.size != '0) begin
         slot_taken[t.slot] = 1'b0;
      end
      @(posedge clk);
      if (in_use !== '0) begin
         check_fail($sformatf("in_use %b after eof, expected 000", in_use));
      end
   endtask

   task automatic check_low(input int n, input logic sel_hdr);
      repeat (n) begin
         @(posedge clk);
         if ((sel_hdr ? hdr_ready : pre_prefix_ready) !== 1'b0) begin
            check_fail(sel_hdr ? "hdr_ready high with stages full" :
                                 "pre_prefix_ready high with no free slot");
         end
      end
   endtask

   task automatic finish_test(input int num, input string name, input int errs_before);
      int n;
      n = 0;
      while ((wr_exp.size() != 0 || load_exp.size() != 0) && n < IDLE_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (wr_exp.size() != 0 || load_exp.size() != 0) begin
         $display("outputs missing at %0t: %0d line writes and %0d loads never came",
                  $time, wr_exp.size(), load_exp.size());
         err_cnt++;
         wr_exp.delete();
         load_exp.delete();
      end
      $display("test %0d %s: %0d errors", num, name, err_cnt - errs_before);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // output monitor.
   always @(posedge clk) begin
      if (rst_n) begin
         if (hb_wr.wr) begin
            wr_seen++;
            if (wr_exp.size() == 0) begin
               $display("unexpected history-buffer write at %0t", $time);
               err_cnt++;
            end else begin
               exp_w = wr_exp.pop_front();
               chk_cnt++;
               if (hb_wr !== exp_w) begin
                  check_fail($sformatf("write slot %0d addr %0d data %h, expected %0d %0d %h",
                     hb_wr.slot, hb_wr.addr, hb_wr.data, exp_w.slot, exp_w.addr, exp_w.data));
               end
            end
         end
         if (ep_load.load || ag_tail.load) begin
            loads_seen++;
            if (load_exp.size() == 0) begin
               $display("unexpected expander load at %0t", $time);
               err_cnt++;
            end else begin
               exp_ld = load_exp.pop_front();
               chk_cnt++;
               if (!(ep_load.load && ag_tail.load) || ep_load.prefix_cnt !== exp_ld.cnt ||
                   ep_load.trace !== exp_ld.trace || ag_tail.tail_ptr !== exp_ld.tail ||
                   in_use !== exp_ld.slots) begin
                  check_fail($sformatf("load cnt %0d trace %b tail %0d in_use %b, exp %0d %b %0d %b",
                     ep_load.prefix_cnt, ep_load.trace, ag_tail.tail_ptr, in_use,
                     exp_ld.cnt, exp_ld.trace, exp_ld.tail, exp_ld.slots));
               end
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the tests did not complete", cycle_cnt);
         $display("Test FAILED");
         $finish;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence.
   initial begin
      int errs;
      int wr_base;
      rst_n      <= 1'b0;
      beat_valid <= 1'b0;
      beat       <= '0;
      hdr_valid  <= 1'b0;
      hdr        <= '0;
      eof        <= 1'b0;
      slot_taken = '0;
      cur_slot   = -1;
      loads_seen = 0;
      eofs_sent  = 0;
      wr_seen    = 0;
      err_cnt    = 0;
      chk_cnt    = 0;
      void'($urandom(32'h9a3aa7f2));
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      // test 1, one 16-beat prefix into slot 0.
      errs = err_cnt;
      if (!pre_prefix_ready || !hdr_ready || in_use !== '0 || hb_wr.wr || ep_load.load ||
          ag_tail.load) begin
         check_fail("outputs after reset not idle");
      end
      wr_base = wr_seen;
      send_prefix(16);
      send_hdr(3, 1'b1);
      send_eof();
      if (wr_seen - wr_base != 8) begin
         check_fail($sformatf("%0d line writes, expected 8", wr_seen - wr_base));
      end
      finish_test(1, "beat packing", errs);

      // test 2, three prefixes fill every slot.
      errs = err_cnt;
      send_prefix(8);
      send_hdr(7, 1'b0);
      send_prefix(8);
      send_hdr(8, 1'b1);
      send_prefix(8);
      send_hdr(9, 1'b0);
      check_low(20, 1'b0);
      send_eof();
      wr_base = 0;
      while (!pre_prefix_ready && wr_base < 10) begin
         @(posedge clk);
         wr_base++;
      end
      if (!pre_prefix_ready) begin
         check_fail("pre_prefix_ready stayed low after a slot release");
      end
      send_eof();
      send_eof();
      finish_test(2, "slot allocation", errs);

      // test 3, count, trace and tail for several sizes.
      errs = err_cnt;
      send_prefix(4);
      send_hdr(1, 1'b1);
      send_eof();
      send_prefix(4);
      send_hdr(45, 1'b0);
      send_eof();
      send_prefix(4);
      send_hdr(127, 1'b1);
      send_eof();
      finish_test(3, "expander loads", errs);

      // test 4, release on eof and the zero-size descriptor.
      errs = err_cnt;
      send_prefix(8);
      send_hdr(5, 1'b1);
      while (loads_seen <= eofs_sent) begin
         @(posedge clk);
      end
      if (in_use !== 3'b001) begin
         check_fail($sformatf("in_use %b while slot 0 holds, expected 001", in_use));
      end
      send_eof();
      send_hdr(0, 1'b0);
      send_eof();
      send_prefix(4);
      send_hdr(2, 1'b0);
      send_eof();
      finish_test(4, "slot release", errs);

      // test 5, back-pressure from the descriptor stages.
      errs = err_cnt;
      send_prefix(4);
      send_hdr(10, 1'b0);
      send_prefix(4);
      send_hdr(20, 1'b1);
      send_prefix(4);
      send_hdr(30, 1'b0);
      check_low(10, 1'b1);
      send_eof();
      send_hdr(0, 1'b1);
      check_low(10, 1'b1);
      send_eof();
      send_prefix(4);
      send_hdr(40, 1'b1);
      send_eof();
      send_eof();
      send_eof();
      finish_test(5, "back-pressure", errs);

      $display("tests 5, outputs compared %0d, errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: prefix_loader.f
+incdir+design
design/pl_pkg.sv
design/pl_slot_ctrl.sv
design/pl_beat_packer.sv
design/pl_desc_pipe.sv
design/prefix_loader.sv
verif/prefix_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the prefix loader testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=prefix_loader_sim

verilator --binary --timing --assert -Wno-fatal \
   -f prefix_loader.f \
   --top-module prefix_loader_tb \
   --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi
exit 0
